// File: bus_pkg.sv
`default_nettype none

package bus_pkg;

  // Bus widths
  localparam int AddrWidth = 32;
  localparam int DataWidth = 32;
  localparam int BeWidth   = DataWidth / 8;

  // One request from the host, a single-cycle strobe
  typedef struct packed {
    logic                 valid;
    logic                 we;
    logic [BeWidth-1:0]   be;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } bus_req_t;

  // Response, one cycle after its request
  typedef struct packed {
    logic                 valid;
    logic                 err;
    logic [DataWidth-1:0] rdata;
  } bus_rsp_t;

endpackage

`default_nettype wire

// File: soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

  // GPIO region, 4 KiB
  localparam logic [bus_pkg::AddrWidth-1:0] GpioSize  = 4 * 1024;
  localparam logic [bus_pkg::AddrWidth-1:0] GpioStart = 32'h80000000;
  localparam logic [bus_pkg::AddrWidth-1:0] GpioMask  = ~(GpioSize - 1);

  // PWM region, 4 KiB, only the first NrPwm * PwmStride bytes are mapped
  localparam logic [bus_pkg::AddrWidth-1:0] PwmSize  = 4 * 1024;
  localparam logic [bus_pkg::AddrWidth-1:0] PwmStart = 32'h80003000;
  localparam logic [bus_pkg::AddrWidth-1:0] PwmMask  = ~(PwmSize - 1);

  // Peripheral sizes
  localparam int GpiWidth   = 8;
  localparam int GpoWidth   = 16;
  localparam int NrPwm      = 4;
  localparam int PwmCtrSize = 8;

  localparam int unsigned PwmStride = 8;

  // Picks one of the two registers inside a block
  localparam int RegOffsetBit = 2;

  // Returned by the error stub
  localparam logic [bus_pkg::DataWidth-1:0] UnmappedRdata = 32'hdecea5ed;

  // Response sources, Unmapped must stay last
  typedef enum int {
    Gpio = 0,
    Pwm0,
    Pwm1,
    Pwm2,
    Pwm3,
    Unmapped
  } dev_e;

  localparam int NrDevices = Unmapped + 1;

  typedef logic [NrDevices-1:0] dev_sel_t;

endpackage

`default_nettype wire

// File: bus_decoder.sv
`default_nettype none

module bus_decoder (
  input  bus_pkg::bus_req_t     bus_req_i,
  output soc_map_pkg::dev_sel_t sel_o
);

  import bus_pkg::*;
  import soc_map_pkg::*;

  logic                 gpio_hit;
  logic                 pwm_region;
  logic                 pwm_hit;
  logic [AddrWidth-1:0] pwm_offs;
  logic [AddrWidth-1:0] pwm_chan;

  assign gpio_hit   = (bus_req_i.addr & GpioMask) == GpioStart;
  assign pwm_region = (bus_req_i.addr & PwmMask) == PwmStart;

  // Offset inside the PWM region and the channel it falls in
  assign pwm_offs = bus_req_i.addr & ~PwmMask;
  assign pwm_chan = pwm_offs / PwmStride;

  // Upper part of the PWM region has no channel behind it
  assign pwm_hit = pwm_region && (pwm_offs < NrPwm * PwmStride);

  always_comb begin
    sel_o = '0;
    if (bus_req_i.valid) begin
      if (gpio_hit) begin
        sel_o[Gpio] = 1'b1;
      end else if (pwm_hit) begin
        for (int i = 0; i < NrPwm; i++) begin
          if (pwm_chan == i) begin
            sel_o[Pwm0 + i] = 1'b1;
          end
        end
      end else begin
        // Everything else goes to the error stub
        sel_o[Unmapped] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: gpio_regs.sv
`default_nettype none

module gpio_regs (
  input  logic                             clk_sys_i,
  input  logic                             rst_sys_ni,
  input  bus_pkg::bus_req_t                bus_req_i,
  input  logic                             sel_i,
  output logic [bus_pkg::DataWidth-1:0]    rdata_o,
  input  logic [soc_map_pkg::GpiWidth-1:0] gp_i,
  output logic [soc_map_pkg::GpoWidth-1:0] gp_o
);

  import bus_pkg::*;
  import soc_map_pkg::*;

  logic [GpiWidth-1:0]  gpi_sync_q;
  logic [GpiWidth-1:0]  gpi_q;
  logic [GpoWidth-1:0]  gpo_q;
  logic [GpoWidth-1:0]  gpo_d;
  logic [GpoWidth-1:0]  be_mask;
  logic                 gpo_we;
  logic [DataWidth-1:0] rdata_d;
  logic [DataWidth-1:0] rdata_q;

  // Expand byte enables to a bit mask
  always_comb begin
    for (int i = 0; i < GpoWidth / 8; i++) begin
      be_mask[i*8 +: 8] = {8{bus_req_i.be[i]}};
    end
  end

  assign gpo_we = sel_i && bus_req_i.we && !bus_req_i.addr[RegOffsetBit];
  assign gpo_d  = (gpo_q & ~be_mask) |
                  (bus_req_i.wdata[GpoWidth-1:0] & be_mask);

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpi_sync_q <= '0;
      gpi_q      <= '0;
      gpo_q      <= '0;
    end else begin
      // Two-flop synchroniser for the asynchronous inputs
      gpi_sync_q <= gp_i;
      gpi_q      <= gpi_sync_q;
      if (gpo_we) begin
        gpo_q <= gpo_d;
      end
    end
  end

  // Offset 4 reads GPI, offset 0 reads GPO, rest of region aliases
  assign rdata_d = bus_req_i.addr[RegOffsetBit] ? DataWidth'(gpi_q) : DataWidth'(gpo_q);

  always_ff @(posedge clk_sys_i) begin
    if (sel_i) begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o = rdata_q;
  assign gp_o    = gpo_q;

endmodule

`default_nettype wire

// File: pwm_channel.sv
`default_nettype none

module pwm_channel (
  input  logic                          clk_sys_i,
  input  logic                          rst_sys_ni,
  input  bus_pkg::bus_req_t             bus_req_i,
  input  logic                          sel_i,
  output logic [bus_pkg::DataWidth-1:0] rdata_o,
  output logic                          pwm_o
);

  import bus_pkg::*;
  import soc_map_pkg::*;

  logic [PwmCtrSize-1:0] pulse_width_q;
  logic [PwmCtrSize-1:0] period_q;
  logic [PwmCtrSize-1:0] ctr_q;
  logic                  reg_we;
  logic                  period_sel;
  logic [DataWidth-1:0]  rdata_d;
  logic [DataWidth-1:0]  rdata_q;

  assign period_sel = bus_req_i.addr[RegOffsetBit];

  // Only the low byte is writable
  assign reg_we = sel_i && bus_req_i.we && bus_req_i.be[0];

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      pulse_width_q <= '0;
      period_q      <= '0;
    end else if (reg_we) begin
      if (period_sel) begin
        period_q <= bus_req_i.wdata[PwmCtrSize-1:0];
      end else begin
        pulse_width_q <= bus_req_i.wdata[PwmCtrSize-1:0];
      end
    end
  end

  // Counts 0 to period inclusive, a period of 0 holds it at 0
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      ctr_q <= '0;
    end else if (ctr_q >= period_q) begin
      // Also catches a period lowered below the current count
      ctr_q <= '0;
    end else begin
      ctr_q <= ctr_q + 1'b1;
    end
  end

  assign pwm_o = ctr_q < pulse_width_q;

  assign rdata_d = period_sel ? DataWidth'(period_q) : DataWidth'(pulse_width_q);

  always_ff @(posedge clk_sys_i) begin
    if (sel_i) begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: rsp_mux.sv
`default_nettype none

module rsp_mux (
  input  logic                  clk_sys_i,
  input  logic                  rst_sys_ni,
  input  logic                  req_valid_i,
  input  soc_map_pkg::dev_sel_t sel_i,
  // One word per real device, the Unmapped slot has no device behind it
  input  logic [soc_map_pkg::Unmapped-1:0][bus_pkg::DataWidth-1:0] dev_rdata_i,
  output bus_pkg::bus_rsp_t     bus_rsp_o
);

  import bus_pkg::*;
  import soc_map_pkg::*;

  logic                 valid_q;
  dev_sel_t             sel_q;
  logic [DataWidth-1:0] dev_rdata;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      valid_q <= 1'b0;
      sel_q   <= '0;
    end else begin
      valid_q <= req_valid_i;
      sel_q   <= sel_i;
    end
  end

  // One-hot AND-OR mux over the devices
  always_comb begin
    dev_rdata = '0;
    for (int i = 0; i < Unmapped; i++) begin
      if (sel_q[i]) begin
        dev_rdata = dev_rdata | dev_rdata_i[i];
      end
    end
  end

  // Error stub answers unmapped addresses
  assign bus_rsp_o.valid = valid_q;
  assign bus_rsp_o.err   = sel_q[Unmapped];
  assign bus_rsp_o.rdata = sel_q[Unmapped] ? UnmappedRdata : dev_rdata;

endmodule

`default_nettype wire

// File: demo_periph_top.sv
`default_nettype none

module demo_periph_top (
  input  logic                             clk_sys_i,
  input  logic                             rst_sys_ni,
  input  bus_pkg::bus_req_t                bus_req_i,
  output bus_pkg::bus_rsp_t                bus_rsp_o,
  input  logic [soc_map_pkg::GpiWidth-1:0] gp_i,
  output logic [soc_map_pkg::GpoWidth-1:0] gp_o,
  output logic [soc_map_pkg::NrPwm-1:0]    pwm_o
);

  import bus_pkg::*;
  import soc_map_pkg::*;

  dev_sel_t                            sel;
  logic [Unmapped-1:0][DataWidth-1:0]  dev_rdata;

  bus_decoder u_bus_decoder (
    .bus_req_i (bus_req_i),
    .sel_o     (sel)
  );

  gpio_regs u_gpio_regs (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .bus_req_i  (bus_req_i),
    .sel_i      (sel[Gpio]),
    .rdata_o    (dev_rdata[Gpio]),
    .gp_i       (gp_i),
    .gp_o       (gp_o)
  );

  // Channel i answers at PwmStart + i * PwmStride
  for (genvar i = 0; i < NrPwm; i++) begin : g_pwm
    pwm_channel u_pwm_channel (
      .clk_sys_i  (clk_sys_i),
      .rst_sys_ni (rst_sys_ni),
      .bus_req_i  (bus_req_i),
      .sel_i      (sel[Pwm0 + i]),
      .rdata_o    (dev_rdata[Pwm0 + i]),
      .pwm_o      (pwm_o[i])
    );
  end

  rsp_mux u_rsp_mux (
    .clk_sys_i   (clk_sys_i),
    .rst_sys_ni  (rst_sys_ni),
    .req_valid_i (bus_req_i.valid),
    .sel_i       (sel),
    .dev_rdata_i (dev_rdata),
    .bus_rsp_o   (bus_rsp_o)
  );

endmodule

`default_nettype wire

// File: tb_demo_periph.sv
`default_nettype none

module tb_demo_periph;

  import bus_pkg::*;
  import soc_map_pkg::*;

  localparam int NrRequests = 2000;
  localparam int PwmRounds  = 4;
  // 2000 random cycles plus 16 PWM windows of at most 263 cycles, with wide margin
  localparam int TimeoutCycles = 30000;

  // Expected response for one request, plus gp_o once its write has landed
  typedef struct packed {
    logic                 valid;
    logic                 err;
    logic                 chk_rdata;
    logic [DataWidth-1:0] rdata;
    logic [GpoWidth-1:0]  gpo;
  } exp_rsp_t;

  logic                  clk_sys;
  logic                  rst_sys_n;
  bus_req_t              bus_req;
  bus_rsp_t              bus_rsp;
  logic [GpiWidth-1:0]   gp_in;
  logic [GpoWidth-1:0]   gp_out;
  logic [NrPwm-1:0]      pwm_out;

  // Reference model
  exp_rsp_t              exp_q[$];
  logic [GpoWidth-1:0]   gpo_model;
  logic [GpiWidth-1:0]   gpi_model;
  int                    gpi_stable;
  logic [PwmCtrSize-1:0] pw_model [NrPwm];
  logic [PwmCtrSize-1:0] per_model [NrPwm];
  int                    errors;
  int                    checks;
  int                    cycles;

  demo_periph_top demo_periph_top_i (
    .clk_sys_i  (clk_sys),
    .rst_sys_ni (rst_sys_n),
    .bus_req_i  (bus_req),
    .bus_rsp_o  (bus_rsp),
    .gp_i       (gp_in),
    .gp_o       (gp_out),
    .pwm_o      (pwm_out)
  );

  initial begin
    clk_sys = 1'b0;
    forever #10 clk_sys = ~clk_sys;
  end

  initial begin
    cycles = 0;
    while (cycles < TimeoutCycles) begin
      @(posedge clk_sys);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
    $display("CHECKS FAILED");
    $finish;
  end

  task automatic log_error(input string msg);
    errors++;
    $display("Error at time %0t: %s", $time, msg);
  endtask

  // Response seen now belongs to the request driven one cycle earlier
  task automatic check_response();
    exp_rsp_t exp;
    if (exp_q.size() >= 2) begin
      exp = exp_q.pop_front();
      checks++;
      if (bus_rsp.valid !== exp.valid) begin
        log_error($sformatf("rsp valid %b, expected %b", bus_rsp.valid, exp.valid));
      end
      if (exp.valid && bus_rsp.err !== exp.err) begin
        log_error($sformatf("rsp err %b, expected %b", bus_rsp.err, exp.err));
      end
      if (exp.valid && exp.chk_rdata && bus_rsp.rdata !== exp.rdata) begin
        log_error($sformatf("rdata %h, expected %h", bus_rsp.rdata, exp.rdata));
      end
      if (gp_out !== exp.gpo) begin
        log_error($sformatf("gp_o %h, expected %h", gp_out, exp.gpo));
      end
    end
  endtask

  // One clock cycle: drive on the rising edge, update model, check on the falling edge
  task automatic step(input bus_req_t req, input int dev, input logic new_gpi,
                      input logic [GpiWidth-1:0] gpi_val);
    exp_rsp_t exp;
    int       ch;
    @(posedge clk_sys);
    bus_req <= req;
    if (new_gpi) begin
      gp_in      <= gpi_val;
      gpi_model  = gpi_val;
      gpi_stable = 0;
    end else begin
      gpi_stable++;
    end
    exp = '0;
    exp.valid = req.valid;
    if (req.valid && dev == Unmapped) begin
      exp.err       = 1'b1;
      exp.chk_rdata = 1'b1;
      exp.rdata     = UnmappedRdata;
    end else if (req.valid && dev == Gpio) begin
      if (req.addr[RegOffsetBit]) begin
        // GPI goes through two flops, so only trust it when settled
        exp.rdata     = DataWidth'(gpi_model);
        exp.chk_rdata = !req.we && gpi_stable >= 3;
      end else begin
        exp.rdata     = DataWidth'(gpo_model);
        exp.chk_rdata = !req.we;
        if (req.we) begin
          for (int i = 0; i < GpoWidth / 8; i++) begin
            if (req.be[i]) begin
              gpo_model[i*8 +: 8] = req.wdata[i*8 +: 8];
            end
          end
        end
      end
    end else if (req.valid) begin
      ch = dev - Pwm0;
      exp.rdata     = req.addr[RegOffsetBit] ? DataWidth'(per_model[ch]) :
                                               DataWidth'(pw_model[ch]);
      exp.chk_rdata = !req.we;
      if (req.we && req.be[0]) begin
        if (req.addr[RegOffsetBit]) begin
          per_model[ch] = req.wdata[PwmCtrSize-1:0];
        end else begin
          pw_model[ch] = req.wdata[PwmCtrSize-1:0];
        end
      end
    end
    exp.gpo = gpo_model;
    exp_q.push_back(exp);
    @(negedge clk_sys);
    check_response();
  endtask

  task automatic idle_cycle();
    step('0, -1, 1'b0, '0);
  endtask

  task automatic random_cycle();
    bus_req_t req;
    int       kind;
    int       dev;
    int       ch;
    logic     new_gpi;
    logic [GpiWidth-1:0] gpi_val;
    req.valid = 1'b1;
    req.we    = $urandom_range(0, 1);
    req.be    = $urandom_range(0, 15);
    req.wdata = $urandom();
    kind      = $urandom_range(0, 9);
    new_gpi   = ($urandom_range(0, 7) == 0);
    gpi_val   = $urandom();
    if (kind < 2) begin
      req.valid = 1'b0;
      req.addr  = $urandom();
      dev       = -1;
    end else if (kind < 5) begin
      dev      = Gpio;
      req.addr = GpioStart + 4 * $urandom_range(0, 1023);
    end else if (kind < 8) begin
      ch       = $urandom_range(0, NrPwm - 1);
      dev      = Pwm0 + ch;
      req.addr = PwmStart + ch * PwmStride + 4 * $urandom_range(0, 1);
    end else begin
      dev = Unmapped;
      if ($urandom_range(0, 1)) begin
        // Unused upper part of the PWM region
        req.addr = PwmStart + NrPwm * PwmStride +
                   4 * $urandom_range(0, (PwmSize - NrPwm * PwmStride) / 4 - 1);
      end else begin
        req.addr = $urandom();
        if ((req.addr & GpioMask) == GpioStart || (req.addr & PwmMask) == PwmStart) begin
          req.addr[28] = ~req.addr[28];
        end
      end
    end
    step(req, dev, new_gpi, gpi_val);
  endtask

  // Program one channel, read it back, then count high cycles over one period
  task automatic pwm_window(input int ch);
    bus_req_t              req;
    logic [PwmCtrSize-1:0] pw;
    logic [PwmCtrSize-1:0] per;
    int                    high;
    int                    expected;
    pw        = $urandom();
    per       = $urandom();
    req.valid = 1'b1;
    req.we    = 1'b1;
    req.be    = $urandom_range(0, 15) | 1;
    req.wdata = $urandom();
    req.wdata[PwmCtrSize-1:0] = pw;
    req.addr  = PwmStart + ch * PwmStride;
    step(req, Pwm0 + ch, 1'b0, '0);
    req.wdata = $urandom();
    req.wdata[PwmCtrSize-1:0] = per;
    req.addr  = req.addr + 4;
    step(req, Pwm0 + ch, 1'b0, '0);
    req.we = 1'b0;
    step(req, Pwm0 + ch, 1'b0, '0);
    req.addr = req.addr - 4;
    step(req, Pwm0 + ch, 1'b0, '0);
    repeat (3) idle_cycle();
    high = 0;
    for (int k = 0; k <= int'(per); k++) begin
      idle_cycle();
      if (pwm_out[ch]) begin
        high++;
      end
    end
    expected = (int'(pw) < int'(per) + 1) ? int'(pw) : int'(per) + 1;
    checks++;
    if (high != expected) begin
      log_error($sformatf("pwm %0d high for %0d cycles, expected %0d (pw %0d, period %0d)",
                          ch, high, expected, pw, per));
    end
  endtask

  initial begin
    void'($urandom(32'hbfe7ed5e));
    bus_req    = '0;
    gp_in      = '0;
    rst_sys_n  = 1'b0;
    gpo_model  = '0;
    gpi_model  = '0;
    gpi_stable = 0;
    errors     = 0;
    checks     = 0;
    for (int i = 0; i < NrPwm; i++) begin
      pw_model[i]  = '0;
      per_model[i] = '0;
    end
    repeat (3) @(posedge clk_sys);
    rst_sys_n <= 1'b1;
    @(negedge clk_sys);
    checks++;
    if (bus_rsp.valid !== 1'b0 || gp_out !== '0 || pwm_out !== '0) begin
      log_error($sformatf("after reset valid %b gp_o %h pwm_o %b",
                          bus_rsp.valid, gp_out, pwm_out));
    end
    // Idle bus while reset ended
    exp_q.push_back('0);
    repeat (NrRequests) random_cycle();
    for (int r = 0; r < PwmRounds; r++) begin
      for (int ch = 0; ch < NrPwm; ch++) begin
        pwm_window(ch);
      end
    end
    repeat (2) idle_cycle();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
bus_pkg.sv
soc_map_pkg.sv
bus_decoder.sv
gpio_regs.sv
pwm_channel.sv
rsp_mux.sv
demo_periph_top.sv
tb_demo_periph.sv
